// File: hw/gpio_pkg.sv
`default_nettype none

package gpio_pkg;

    localparam int GPIO_WIDTH = 16;
    localparam int DATA_WIDTH = 32;
    localparam int ADDR_WIDTH = 32;
    localparam int STRB_WIDTH = DATA_WIDTH / 8;
    localparam int NUM_ALT    = 3;
    localparam int NUM_REGS   = 7;

    // Byte offsets of the register map, one 32-bit word per register.
    localparam logic [ADDR_WIDTH-1:0] REG_IDR    = 32'h00;
    localparam logic [ADDR_WIDTH-1:0] REG_ODR    = 32'h04;
    localparam logic [ADDR_WIDTH-1:0] REG_MODER  = 32'h08;
    localparam logic [ADDR_WIDTH-1:0] REG_OTYPER = 32'h0C;
    localparam logic [ADDR_WIDTH-1:0] REG_FSR0   = 32'h10;
    localparam logic [ADDR_WIDTH-1:0] REG_FSR1   = 32'h14;
    localparam logic [ADDR_WIDTH-1:0] REG_IER    = 32'h18;

    typedef enum logic [2:0] {
        IDX_IDR    = 3'd0,
        IDX_ODR    = 3'd1,
        IDX_MODER  = 3'd2,
        IDX_OTYPER = 3'd3,
        IDX_FSR0   = 3'd4,
        IDX_FSR1   = 3'd5,
        IDX_IER    = 3'd6
    } reg_idx_e;

    typedef struct packed {
        logic [ADDR_WIDTH-1:0] paddr;
        logic                  pwrite;
        logic [DATA_WIDTH-1:0] pwdata;
        logic [STRB_WIDTH-1:0] pstrb;
        logic                  psel;
        logic                  penable;
    } apb_req_t;

    typedef struct packed {
        logic [DATA_WIDTH-1:0] prdata;
        logic                  pready;
        logic                  pslverr;
    } apb_rsp_t;

    typedef struct packed {
        logic                      en;
        reg_idx_e                  idx;
        logic [GPIO_WIDTH-1:0]     data;
        logic [GPIO_WIDTH/8-1:0]   strb; // Only the two low bytes carry bits.
    } reg_wr_t;

    typedef struct packed {
        logic [GPIO_WIDTH-1:0] odr;
        logic [GPIO_WIDTH-1:0] moder;
        logic [GPIO_WIDTH-1:0] otyper;
        logic [GPIO_WIDTH-1:0] fsr0;
        logic [GPIO_WIDTH-1:0] fsr1;
        logic [GPIO_WIDTH-1:0] ier;
    } gpio_cfg_t;

    typedef struct packed {
        logic [GPIO_WIDTH-1:0] o;
        logic [GPIO_WIDTH-1:0] oe;
    } pin_out_t;

endpackage

`default_nettype wire

// File: hw/gpio_reg_ctrl.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_reg_ctrl (
    input  wire logic                            seq,
    input  wire logic                            reset,
    input  wire gpio_pkg::apb_req_t              apb_req,
    input  wire gpio_pkg::gpio_cfg_t             cfg,
    input  wire logic [gpio_pkg::GPIO_WIDTH-1:0] idr,
    output gpio_pkg::apb_rsp_t                   apb_rsp,
    output gpio_pkg::reg_wr_t                    reg_wr
);

    import gpio_pkg::*;

    reg_idx_e              idx;
    logic                  mapped;
    logic                  err;
    logic                  access;
    logic                  answered;
    logic [GPIO_WIDTH-1:0] reg_view [NUM_REGS];

    // Full address compare, so misaligned offsets fall through to the default.
    always_comb begin
        mapped = 1'b1;
        idx    = IDX_IDR;
        case (apb_req.paddr)
            REG_IDR:    idx = IDX_IDR;
            REG_ODR:    idx = IDX_ODR;
            REG_MODER:  idx = IDX_MODER;
            REG_OTYPER: idx = IDX_OTYPER;
            REG_FSR0:   idx = IDX_FSR0;
            REG_FSR1:   idx = IDX_FSR1;
            REG_IER:    idx = IDX_IER;
            default:    mapped = 1'b0;
        endcase
    end

    assign err = !mapped || (apb_req.pwrite && idx == IDX_IDR); // IDR is read-only.

    // A master that holds penable past the first access cycle gets no second answer.
    always_ff @(posedge seq) begin
        if (reset) begin
            answered <= 1'b0;
        end else begin
            answered <= apb_req.psel && apb_req.penable;
        end
    end

    assign access = apb_req.psel && apb_req.penable && !answered;

    always_comb begin
        reg_view[IDX_IDR]    = idr;
        reg_view[IDX_ODR]    = cfg.odr;
        reg_view[IDX_MODER]  = cfg.moder;
        reg_view[IDX_OTYPER] = cfg.otyper;
        reg_view[IDX_FSR0]   = cfg.fsr0;
        reg_view[IDX_FSR1]   = cfg.fsr1;
        reg_view[IDX_IER]    = cfg.ier;
    end

    always_comb begin
        apb_rsp.pready  = access;
        apb_rsp.pslverr = access && err;
        if (mapped) begin
            apb_rsp.prdata = {{(DATA_WIDTH - GPIO_WIDTH){1'b0}}, reg_view[idx]};
        end else begin
            apb_rsp.prdata = '0;
        end
    end

    always_comb begin
        reg_wr.en   = access && apb_req.pwrite && !err;
        reg_wr.idx  = idx;
        reg_wr.data = apb_req.pwdata[GPIO_WIDTH-1:0];
        reg_wr.strb = apb_req.pstrb[GPIO_WIDTH/8-1:0]; // Upper strobes address no bits.
    end

endmodule

`default_nettype wire

// File: hw/gpio_reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_reg_file (
    input  wire logic              seq,
    input  wire logic              reset,
    input  wire gpio_pkg::reg_wr_t reg_wr,
    output gpio_pkg::gpio_cfg_t    cfg
);

    import gpio_pkg::*;

    // Replace only the bytes whose strobe is set.
    function automatic logic [GPIO_WIDTH-1:0] merge_bytes(
        input logic [GPIO_WIDTH-1:0] old_value,
        input reg_wr_t               wr
    );
        logic [GPIO_WIDTH-1:0] result;
        result = old_value;
        for (int b = 0; b < GPIO_WIDTH / 8; b++) begin
            if (wr.strb[b]) begin
                result[b*8 +: 8] = wr.data[b*8 +: 8];
            end
        end
        return result;
    endfunction

    always_ff @(posedge seq) begin
        if (reset) begin
            cfg <= '0;
        end else if (reg_wr.en) begin
            case (reg_wr.idx)
                IDX_ODR: begin
                    cfg.odr <= merge_bytes(cfg.odr, reg_wr);
                end
                IDX_MODER: begin
                    cfg.moder <= merge_bytes(cfg.moder, reg_wr);
                end
                IDX_OTYPER: begin
                    cfg.otyper <= merge_bytes(cfg.otyper, reg_wr);
                end
                IDX_FSR0: begin
                    cfg.fsr0 <= merge_bytes(cfg.fsr0, reg_wr);
                end
                IDX_FSR1: begin
                    cfg.fsr1 <= merge_bytes(cfg.fsr1, reg_wr);
                end
                IDX_IER: begin
                    cfg.ier <= merge_bytes(cfg.ier, reg_wr);
                end
                default: begin
                    cfg <= cfg; // IDR lives in the input synchronizer.
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// File: hw/gpio_input_sync.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_input_sync (
    input  wire logic                            seq,
    input  wire logic                            reset,
    input  wire logic [gpio_pkg::GPIO_WIDTH-1:0] pins_in,
    input  wire logic [gpio_pkg::GPIO_WIDTH-1:0] ier,
    output logic [gpio_pkg::GPIO_WIDTH-1:0]      idr,
    output logic                                 irq
);

    import gpio_pkg::*;

    logic [GPIO_WIDTH-1:0] meta; // First stage, may go metastable.

    always_ff @(posedge seq) begin
        if (reset) begin
            meta <= '0;
            idr  <= '0;
        end else begin
            meta <= pins_in;
            idr  <= meta;
        end
    end

    // The interrupt is level sensitive and follows IDR by one edge.
    always_ff @(posedge seq) begin
        if (reset) begin
            irq <= 1'b0;
        end else begin
            irq <= |(ier & idr);
        end
    end

endmodule

`default_nettype wire

// File: hw/gpio_pin_mux.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_pin_mux (
    input  wire gpio_pkg::gpio_cfg_t                                     cfg,
    input  wire logic [gpio_pkg::NUM_ALT-1:0][gpio_pkg::GPIO_WIDTH-1:0] alt_out,
    output gpio_pkg::pin_out_t                                           pins
);

    import gpio_pkg::*;

    logic [2*GPIO_WIDTH-1:0] fsr;
    logic [1:0]              func [GPIO_WIDTH];
    logic [GPIO_WIDTH-1:0]   sel;

    assign fsr = {cfg.fsr1, cfg.fsr0}; // Two bits per pin, pin 0 at the bottom.

    always_comb begin
        for (int p = 0; p < GPIO_WIDTH; p++) begin
            func[p] = fsr[2*p +: 2];
            if (func[p] == 2'd0) begin
                sel[p] = cfg.odr[p];
            end else begin
                sel[p] = alt_out[func[p] - 2'd1][p];
            end
        end
    end

    // An open-drain pin drives only a low level and releases the line for a one.
    assign pins = '{
        o:  sel,
        oe: cfg.moder & ~(cfg.otyper & sel)
    };

endmodule

`default_nettype wire

// File: hw/gpio_periph.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_periph (
    input  wire logic                                                    seq,
    input  wire logic                                                    reset,
    input  wire gpio_pkg::apb_req_t                                      apb_req,
    input  wire logic [gpio_pkg::GPIO_WIDTH-1:0]                         pins_in,
    input  wire logic [gpio_pkg::NUM_ALT-1:0][gpio_pkg::GPIO_WIDTH-1:0] alt_out,
    output gpio_pkg::apb_rsp_t                                           apb_rsp,
    output gpio_pkg::pin_out_t                                           pins,
    output logic                                                         irq
);

    import gpio_pkg::*;

    reg_wr_t               reg_wr;
    gpio_cfg_t             cfg;
    logic [GPIO_WIDTH-1:0] idr;

    gpio_reg_ctrl gpio_reg_ctrl_i (
        .seq     (seq),
        .reset   (reset),
        .apb_req (apb_req),
        .cfg     (cfg),
        .idr     (idr),
        .apb_rsp (apb_rsp),
        .reg_wr  (reg_wr)
    );

    gpio_reg_file gpio_reg_file_i (
        .seq    (seq),
        .reset  (reset),
        .reg_wr (reg_wr),
        .cfg    (cfg)
    );

    gpio_input_sync gpio_input_sync_i (
        .seq     (seq),
        .reset   (reset),
        .pins_in (pins_in),
        .ier     (cfg.ier),
        .idr     (idr),
        .irq     (irq)
    );

    // Pad outputs are combinational from the configuration.
    gpio_pin_mux gpio_pin_mux_i (
        .cfg     (cfg),
        .alt_out (alt_out),
        .pins    (pins)
    );

endmodule

`default_nettype wire

// File: tests/gpio_tb_apb.svh
`ifndef GPIO_TB_APB_SVH
`define GPIO_TB_APB_SVH

// APB master tasks. They share seq, apb_req and apb_rsp with the testbench module.

task automatic wait_ready(output apb_rsp_t rsp);
    do begin
        @(negedge seq); // Response is settled half a cycle after the access edge.
    end while (!apb_rsp.pready);
    rsp = apb_rsp;
endtask

task automatic apb_write(
    input  logic [ADDR_WIDTH-1:0] addr,
    input  logic [DATA_WIDTH-1:0] data,
    input  logic [STRB_WIDTH-1:0] strb,
    output logic                  err
);
    apb_rsp_t rsp;
    @(posedge seq);
    apb_req <= '{paddr: addr, pwrite: 1'b1, pwdata: data, pstrb: strb,
                 psel: 1'b1, penable: 1'b0};
    @(posedge seq);
    apb_req.penable <= 1'b1;
    wait_ready(rsp);
    err = rsp.pslverr;
    @(posedge seq);
    apb_req <= '0; // The write lands on this edge.
endtask

task automatic apb_read(
    input  logic [ADDR_WIDTH-1:0] addr,
    output logic [DATA_WIDTH-1:0] data,
    output logic                  err
);
    apb_rsp_t rsp;
    @(posedge seq);
    apb_req <= '{paddr: addr, pwrite: 1'b0, pwdata: '0, pstrb: '0,
                 psel: 1'b1, penable: 1'b0};
    @(posedge seq);
    apb_req.penable <= 1'b1;
    wait_ready(rsp);
    data = rsp.prdata;
    err  = rsp.pslverr;
    @(posedge seq);
    apb_req <= '0;
endtask

`endif

// File: tests/gpio_periph_tb.sv
`timescale 1ns/100ps
`default_nettype none

module gpio_periph_tb;

    import gpio_pkg::*;

    // About 300 transfers of at most 6 cycles, plus the settling waits.
    localparam int MAX_TRANSFERS   = 300;
    localparam int MAX_XFER_CYCLES = 6;
    localparam int SETTLE_CYCLES   = 1200;
    localparam int MAX_CYCLES      = MAX_TRANSFERS * MAX_XFER_CYCLES + SETTLE_CYCLES;

    localparam logic [31:0] BAD_OFFSETS [7] = '{
        32'h1C, 32'h20, 32'h40, 32'h100, 32'h05, 32'h0A, 32'h13
    };

    logic                               seq;
    logic                               reset;
    apb_req_t                           apb_req;
    apb_rsp_t                           apb_rsp;
    logic [GPIO_WIDTH-1:0]              pins_in;
    logic [NUM_ALT-1:0][GPIO_WIDTH-1:0] alt_out;
    pin_out_t                           pins;
    logic                               irq;

    logic [GPIO_WIDTH-1:0] exp_reg [NUM_REGS]; // Slot 0 stays unused.
    logic [GPIO_WIDTH-1:0] exp_idr = '0;
    logic                  probe;
    logic [15:0]           lfsr_state = 16'd99;
    int                    cycles = 0;
    int                    checks = 0;
    int                    errors = 0;

    gpio_periph gpio_periph_i (
        .seq     (seq),
        .reset   (reset),
        .apb_req (apb_req),
        .pins_in (pins_in),
        .alt_out (alt_out),
        .apb_rsp (apb_rsp),
        .pins    (pins),
        .irq     (irq)
    );

    `include "gpio_tb_apb.svh"

    initial begin
        seq = 1'b0;
        forever #4 seq = ~seq;
    end

    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        return {1'b0, state[15:1]} ^ (state[0] ? 16'hB400 : 16'h0000);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value      = {value[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return value;
    endfunction

    // Expected response of one cycle from the register map rules.
    function automatic apb_rsp_t ref_response(input apb_req_t req);
        apb_rsp_t   rsp;
        logic       mapped;
        logic [2:0] word;
        mapped      = req.paddr[1:0] == 2'b00 && req.paddr < 32'(NUM_REGS * 4);
        word        = req.paddr[4:2];
        rsp.pready  = req.psel && req.penable; // No wait states, one access cycle per transfer.
        rsp.pslverr = rsp.pready && (!mapped || (req.pwrite && word == 3'd0));
        rsp.prdata  = '0;
        if (mapped) begin
            rsp.prdata[GPIO_WIDTH-1:0] = (word == 3'd0) ? exp_idr : exp_reg[word];
        end
        return rsp;
    endfunction

    function automatic pin_out_t ref_pins();
        pin_out_t   pins_exp;
        logic [1:0] fn;
        logic       value;
        for (int p = 0; p < GPIO_WIDTH; p++) begin
            if (p < 8) begin
                fn = exp_reg[IDX_FSR0][2*p +: 2];
            end else begin
                fn = exp_reg[IDX_FSR1][2*(p-8) +: 2];
            end
            if (fn == 2'd0) begin
                value = exp_reg[IDX_ODR][p];
            end else begin
                value = alt_out[int'(fn) - 1][p];
            end
            pins_exp.o[p]  = value;
            pins_exp.oe[p] = exp_reg[IDX_MODER][p] && !(exp_reg[IDX_OTYPER][p] && value);
        end
        return pins_exp;
    endfunction

    task automatic update_model(input apb_req_t req);
        logic [2:0] word;
        word = req.paddr[4:2];
        for (int b = 0; b < 2; b++) begin
            if (req.pstrb[b]) begin
                exp_reg[word][8*b +: 8] = req.pwdata[8*b +: 8];
            end
        end
    endtask

    task automatic check_equal(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Mismatch at %0t ns: %s, got 0x%0h, expected 0x%0h",
                     $time, msg, actual, expected);
        end
    endtask

    // Compares the bus response every cycle, and the pads and irq whenever a probe is raised.
    always @(negedge seq) begin
        apb_rsp_t rsp_exp;
        pin_out_t pins_exp;
        if (reset) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                exp_reg[i] = '0;
            end
        end else begin
            rsp_exp = ref_response(apb_req);
            check_equal(32'(apb_rsp.pready), 32'(rsp_exp.pready), "pready");
            check_equal(32'(apb_rsp.pslverr), 32'(rsp_exp.pslverr),
                        $sformatf("pslverr at offset 0x%0h", apb_req.paddr));
            if (rsp_exp.pready) begin
                if (!apb_req.pwrite && !rsp_exp.pslverr) begin
                    check_equal(apb_rsp.prdata, rsp_exp.prdata,
                                $sformatf("prdata at offset 0x%0h", apb_req.paddr));
                end
                if (apb_req.pwrite && !rsp_exp.pslverr) begin
                    update_model(apb_req);
                end
            end
            if (probe) begin
                pins_exp = ref_pins();
                check_equal(32'(pins.o), 32'(pins_exp.o), "pins.o");
                check_equal(32'(pins.oe), 32'(pins_exp.oe), "pins.oe");
                check_equal(32'(irq), 32'(|(exp_reg[IDX_IER] & exp_idr)), "irq");
            end
        end
    end

    always @(posedge seq) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("Run timed out after %0d cycles", cycles);
            $display("tests failed");
            $finish;
        end
    end

    task automatic probe_outputs();
        @(posedge seq);
        probe <= 1'b1;
        @(posedge seq);
        probe <= 1'b0;
    endtask

    task automatic write_random_value(input logic [31:0] addr);
        logic [31:0] r;
        logic        err;
        r = rand_bits(16);
        apb_write(addr, r, 4'h3, err);
    endtask

    task automatic report_test(input int num, input string name, input int start_errors);
        $display("test %0d %s: %0d errors", num, name, errors - start_errors);
    endtask

    initial begin
        logic [31:0]           r;
        logic [31:0]           data;
        logic                  err;
        logic [GPIO_WIDTH-1:0] ier_val;
        int                    word;
        int                    start;
        reset   <= 1'b1;
        apb_req <= '0;
        pins_in <= '0;
        alt_out <= '0;
        probe   <= 1'b0;
        repeat (5) @(posedge seq);
        reset <= 1'b0;

        start = errors;
        for (int i = 0; i < NUM_REGS; i++) begin
            apb_read(32'(i * 4), data, err);
        end
        probe_outputs();
        report_test(1, "reset values", start);

        start = errors;
        for (int i = 0; i < 100; i++) begin
            r    = rand_bits(4);
            word = int'(r % 9); // Words 7 and 8 are unmapped.
            data = rand_bits(32);
            r    = rand_bits(4);
            apb_write(32'(word * 4), data, r[3:0], err);
            apb_read(32'(word * 4), data, err);
        end
        report_test(2, "random strobed access", start);

        start = errors;
        data  = rand_bits(32);
        apb_write(REG_IDR, data, 4'hF, err);
        for (int i = 0; i < 7; i++) begin
            apb_write(BAD_OFFSETS[i], data, 4'hF, err);
            apb_read(BAD_OFFSETS[i], r, err);
        end
        for (int i = 0; i < NUM_REGS; i++) begin
            apb_read(32'(i * 4), data, err);
        end
        report_test(3, "error responses", start);

        start = errors;
        for (int i = 0; i < 4; i++) begin
            r       = rand_bits(16);
            ier_val = r[15:0];
            apb_write(REG_IER, r, 4'h3, err);
            r = rand_bits(16);
            if (i == 3) begin
                r[15:0] = ~ier_val; // Leaves irq low.
            end
            @(posedge seq);
            pins_in <= r[15:0];
            repeat (3) @(posedge seq);
            exp_idr = r[15:0];
            apb_read(REG_IDR, data, err);
            probe_outputs();
        end
        report_test(4, "input data and irq", start);

        start = errors;
        for (int i = 0; i < 4; i++) begin
            @(posedge seq);
            for (int k = 0; k < NUM_ALT; k++) begin
                r = rand_bits(16);
                alt_out[k] <= r[15:0];
            end
            write_random_value(REG_MODER);
            write_random_value(REG_OTYPER);
            write_random_value(REG_FSR0);
            write_random_value(REG_FSR1);
            write_random_value(REG_ODR);
            probe_outputs();
        end
        report_test(5, "pin outputs", start);

        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: compile.f
+incdir+tests
hw/gpio_pkg.sv
hw/gpio_reg_ctrl.sv
hw/gpio_reg_file.sv
hw/gpio_input_sync.sv
hw/gpio_pin_mux.sv
hw/gpio_periph.sv
tests/gpio_periph_tb.sv

// File: Makefile
TOP := gpio_periph_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

obj_dir/V$(TOP): compile.f $(wildcard hw/*.sv) $(wildcard tests/*.sv) $(wildcard tests/*.svh)
	verilator --binary --timing -f compile.f --top-module $(TOP) -Mdir obj_dir

test: obj_dir/V$(TOP)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "all tests passed"

clean:
	rm -rf obj_dir
